//--- hw/mem_pkg.sv
package mem_pkg;

  // ======================================================================
  // Memory geometry
  // ======================================================================

  localparam int LANES     = 4;   // Words per line, also banks per thread
  localparam int WORD_BITS = 32;
  localparam int THREAD_W  = 6;
  localparam int WORD_W    = 12;

  // Defaults for the top level
  localparam int DEF_NUM_RT      = 4;
  localparam int DEF_NUM_THREAD  = 8;
  localparam int DEF_WORD_ADDR_W = 8;  // 256 words per thread, 64 rows per bank

  // Byte address seen by an RT core
  typedef struct packed {
    logic [9:0]          unused;
    logic [THREAD_W-1:0] thread;    // Bits 21:16
    logic [1:0]          spare;
    logic [WORD_W-1:0]   word;      // Bits 13:2
    logic [1:0]          byte_off;
  } rt_addr_t;

  typedef logic [WORD_BITS-1:0] word_t;

  // Lane k holds the word at start address + k
  typedef word_t [LANES-1:0] line_t;

endpackage

//--- hw/port_pkg.sv
package port_pkg;

  // RT core side, req/rdy handshake
  typedef struct packed {
    logic              valid;
    logic              we;
    mem_pkg::rt_addr_t addr;
    mem_pkg::line_t    wdata;
  } rt_req_t;

  typedef struct packed {
    logic           rdy;
    mem_pkg::line_t rdata;
  } rt_rsp_t;

  // Memory controller access issued by the APB bridge
  typedef struct packed {
    logic                         valid;
    logic                         we;
    logic [mem_pkg::THREAD_W-1:0] thread;
    logic [mem_pkg::WORD_W-1:0]   word;
    mem_pkg::line_t               wdata;
  } mem_cmd_t;

  typedef struct packed {
    logic           done;
    mem_pkg::line_t rdata;
  } mem_rsp_t;

  // ======================================================================
  // APB
  // ======================================================================

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  localparam logic [7:0] REG_DATA0  = 8'h00;
  localparam logic [7:0] REG_DATA1  = 8'h04;
  localparam logic [7:0] REG_DATA2  = 8'h08;
  localparam logic [7:0] REG_DATA3  = 8'h0C;
  localparam logic [7:0] REG_CMD    = 8'h10;
  localparam logic [7:0] REG_STATUS = 8'h14;

  // CMD word at 11:0, thread at 17:12
  localparam int CMD_THREAD_LSB = 12;
  localparam int CMD_WE_BIT     = 31;
  localparam int STAT_BUSY_BIT  = 0;
  localparam int STAT_ERR_BIT   = 1;

endpackage

//--- hw/bank_ram.sv
`timescale 1ns/1ns

module bank_ram #(
  parameter int ADDR_W = 6,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              we,
  input  logic [ADDR_W-1:0] addr,
  input  logic [DATA_W-1:0] din,
  output logic [DATA_W-1:0] dout
);

  logic [DATA_W-1:0] mem [2**ADDR_W];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= din;
    end
    dout <= mem[addr];  // Old data on a write cycle
  end

endmodule

//--- hw/thread_group.sv
`timescale 1ns/1ns

module thread_group #(
  parameter int WORD_ADDR_W = 8
) (
  input  logic                   clk,
  input  logic                   we,
  input  logic [WORD_ADDR_W-1:0] word,
  input  mem_pkg::line_t         wdata,
  output mem_pkg::line_t         rdata
);

  localparam int ROW_W = WORD_ADDR_W - 2;

  logic [1:0]     off;
  logic [1:0]     off_q;     // Start offset of the line now leaving the banks
  mem_pkg::line_t bank_dout; // Indexed by bank, not by lane

  assign off = word[1:0];

  always_ff @(posedge clk) begin
    off_q <= off;
  end

  // ======================================================================
  // Lane to bank rotation
  // ======================================================================

  // Bank b serves lane (b - off), so each line touches every bank once
  for (genvar b = 0; b < mem_pkg::LANES; b++) begin : g_bank
    logic [1:0]             lane;
    logic [WORD_ADDR_W-1:0] lane_word;

    assign lane      = 2'(b) - off;
    assign lane_word = word + WORD_ADDR_W'(lane);  // Wraps inside the thread

    bank_ram #(
      .ADDR_W (ROW_W),
      .DATA_W (mem_pkg::WORD_BITS)
    ) bank_i (
      .clk  (clk),
      .we   (we),
      .addr (lane_word[WORD_ADDR_W-1:2]),
      .din  (wdata[lane]),
      .dout (bank_dout[b])
    );
  end

  // Back into lane order, one cycle later
  for (genvar k = 0; k < mem_pkg::LANES; k++) begin : g_lane
    logic [1:0] src;

    assign src      = 2'(k) + off_q;
    assign rdata[k] = bank_dout[src];
  end

endmodule

//--- hw/mem_main.sv
`timescale 1ns/1ns

module mem_main #(
  parameter int NUM_RT      = 4,
  parameter int NUM_THREAD  = 8,
  parameter int WORD_ADDR_W = 8
) (
  input  logic               clk,
  input  logic               rst_n,
  input  port_pkg::rt_req_t  rt_req [NUM_RT],
  output port_pkg::rt_rsp_t  rt_rsp [NUM_RT],
  input  port_pkg::mem_cmd_t mem_cmd,
  output port_pkg::mem_rsp_t mem_rsp
);

  localparam int TID_W = (NUM_THREAD > 1) ? $clog2(NUM_THREAD) : 1;

  logic [NUM_RT-1:0] grant_all [NUM_THREAD];  // Per thread, one-hot or zero
  mem_pkg::line_t    grp_rdata [NUM_THREAD];

  logic [NUM_RT-1:0] port_acc;
  logic [NUM_RT-1:0] acc_q;                   // Accepted last cycle, rdy now
  logic [TID_W-1:0]  thr_q [NUM_RT];
  logic              mc_acc;
  logic              mc_acc_q;
  logic [TID_W-1:0]  mc_thr_q;

  // ======================================================================
  // Per-thread hit decode and arbitration
  // ======================================================================

  for (genvar t = 0; t < NUM_THREAD; t++) begin : g_thread
    logic [NUM_RT-1:0]      hit;
    logic [NUM_RT-1:0]      grant;
    logic                   mc_sel;
    logic                   grp_we;
    logic [WORD_ADDR_W-1:0] grp_word;
    mem_pkg::line_t         grp_wdata;

    for (genvar p = 0; p < NUM_RT; p++) begin : g_hit
      assign hit[p] = rt_req[p].valid && !acc_q[p] && (rt_req[p].addr.thread == t);
    end

    assign mc_sel = mem_cmd.valid && (mem_cmd.thread == t);

    // MC first, then the lowest set bit of hit
    assign grant        = mc_sel ? '0 : (hit & (~hit + NUM_RT'(1)));
    assign grant_all[t] = grant;

    always_comb begin
      grp_we    = mc_sel & mem_cmd.we;
      grp_word  = mem_cmd.word[WORD_ADDR_W-1:0];
      grp_wdata = mem_cmd.wdata;
      for (int p = 0; p < NUM_RT; p++) begin
        if (grant[p]) begin
          grp_we    = rt_req[p].we;
          grp_word  = rt_req[p].addr.word[WORD_ADDR_W-1:0];
          grp_wdata = rt_req[p].wdata;
        end
      end
    end

    thread_group #(
      .WORD_ADDR_W (WORD_ADDR_W)
    ) group_i (
      .clk   (clk),
      .we    (grp_we),
      .word  (grp_word),
      .wdata (grp_wdata),
      .rdata (grp_rdata[t])
    );
  end

  // A port addresses one thread, so at most one grant bit per port
  always_comb begin
    port_acc = '0;
    for (int t = 0; t < NUM_THREAD; t++) begin
      port_acc = port_acc | grant_all[t];
    end
  end

  assign mc_acc = mem_cmd.valid && (mem_cmd.thread < NUM_THREAD);

  // ======================================================================
  // Response side, one cycle after acceptance
  // ======================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q    <= '0;
      mc_acc_q <= 1'b0;
    end else begin
      acc_q    <= port_acc;
      mc_acc_q <= mc_acc;
    end
  end

  // Which group to read back from
  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_RT; p++) begin
      if (port_acc[p]) begin
        thr_q[p] <= rt_req[p].addr.thread[TID_W-1:0];
      end
    end
    if (mc_acc) begin
      mc_thr_q <= mem_cmd.thread[TID_W-1:0];
    end
  end

  for (genvar p = 0; p < NUM_RT; p++) begin : g_rsp
    assign rt_rsp[p].rdy   = acc_q[p];
    assign rt_rsp[p].rdata = grp_rdata[thr_q[p]];
  end

  assign mem_rsp.done  = mc_acc_q;
  assign mem_rsp.rdata = grp_rdata[mc_thr_q];

endmodule

//--- hw/apb_mc_bridge.sv
`timescale 1ns/1ns

module apb_mc_bridge #(
  parameter int NUM_THREAD = 8
) (
  input  logic               clk,
  input  logic               rst_n,
  input  port_pkg::apb_req_t apb_req,
  output port_pkg::apb_rsp_t apb_rsp,
  output port_pkg::mem_cmd_t mem_cmd,
  input  port_pkg::mem_rsp_t mem_rsp
);

  logic       access;
  logic       sel_data;
  logic       sel_cmd;
  logic       sel_status;
  logic       cmd_wr;
  logic       thr_ok;
  logic       launch;
  logic       refuse;
  logic [1:0] data_idx;

  mem_pkg::line_t               data_q;  // DATA0..3 staging
  logic                         valid_q;
  logic                         busy_q;
  logic                         err_q;
  logic                         we_q;
  logic [mem_pkg::THREAD_W-1:0] thr_q;
  logic [mem_pkg::WORD_W-1:0]   word_q;

  // ======================================================================
  // Decode
  // ======================================================================

  assign access     = apb_req.psel && apb_req.penable;
  assign sel_data   = apb_req.paddr inside {port_pkg::REG_DATA0, port_pkg::REG_DATA1,
                                            port_pkg::REG_DATA2, port_pkg::REG_DATA3};
  assign sel_cmd    = (apb_req.paddr == port_pkg::REG_CMD);
  assign sel_status = (apb_req.paddr == port_pkg::REG_STATUS);
  assign data_idx   = apb_req.paddr[3:2];

  assign cmd_wr = access && sel_cmd && apb_req.pwrite;
  assign thr_ok = apb_req.pwdata[port_pkg::CMD_THREAD_LSB +: mem_pkg::THREAD_W] < NUM_THREAD;
  assign launch = cmd_wr && thr_ok && !busy_q;   // Only in the first access cycle
  assign refuse = cmd_wr && !thr_ok;

  always_comb begin
    apb_rsp.pready  = 1'b0;
    apb_rsp.pslverr = 1'b0;
    if (access) begin
      apb_rsp.pready  = (cmd_wr && thr_ok) ? (busy_q && mem_rsp.done) : 1'b1;
      apb_rsp.pslverr = refuse || !(sel_data || sel_cmd || sel_status);
    end
    case (apb_req.paddr)
      port_pkg::REG_DATA0:  apb_rsp.prdata = data_q[0];
      port_pkg::REG_DATA1:  apb_rsp.prdata = data_q[1];
      port_pkg::REG_DATA2:  apb_rsp.prdata = data_q[2];
      port_pkg::REG_DATA3:  apb_rsp.prdata = data_q[3];
      port_pkg::REG_CMD:    apb_rsp.prdata = {we_q, 13'b0, thr_q, word_q};
      port_pkg::REG_STATUS: apb_rsp.prdata = {30'b0, err_q, busy_q};
      default:              apb_rsp.prdata = '0;
    endcase
  end

  // ======================================================================
  // Staging and command state
  // ======================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      busy_q  <= 1'b0;
      err_q   <= 1'b0;
      data_q  <= '0;
    end else begin
      valid_q <= launch;  // One-cycle pulse
      if (launch) begin
        busy_q <= 1'b1;
      end else if (mem_rsp.done) begin
        busy_q <= 1'b0;
      end
      if (refuse) begin
        err_q <= 1'b1;  // Sticky, write 1 to STATUS bit 1 to clear
      end else if (access && sel_status && apb_req.pwrite
                   && apb_req.pwdata[port_pkg::STAT_ERR_BIT]) begin
        err_q <= 1'b0;
      end
      if (access && sel_data && apb_req.pwrite) begin
        data_q[data_idx] <= apb_req.pwdata;
      end else if (busy_q && mem_rsp.done && !we_q) begin
        data_q <= mem_rsp.rdata;  // Read line lands in DATA0..3
      end
    end
  end

  always_ff @(posedge clk) begin
    if (launch) begin
      we_q   <= apb_req.pwdata[port_pkg::CMD_WE_BIT];
      thr_q  <= apb_req.pwdata[port_pkg::CMD_THREAD_LSB +: mem_pkg::THREAD_W];
      word_q <= apb_req.pwdata[mem_pkg::WORD_W-1:0];
    end
  end

  assign mem_cmd = '{valid: valid_q, we: we_q, thread: thr_q, word: word_q, wdata: data_q};

endmodule

//--- hw/rt_mem_top.sv
`timescale 1ns/1ns

module rt_mem_top #(
  parameter int NUM_RT      = mem_pkg::DEF_NUM_RT,
  parameter int NUM_THREAD  = mem_pkg::DEF_NUM_THREAD,
  parameter int WORD_ADDR_W = mem_pkg::DEF_WORD_ADDR_W
) (
  input  logic               clk,
  input  logic               rst_n,
  input  port_pkg::apb_req_t apb_req,
  output port_pkg::apb_rsp_t apb_rsp,
  input  port_pkg::rt_req_t  rt_req [NUM_RT],
  output port_pkg::rt_rsp_t  rt_rsp [NUM_RT]
);

  port_pkg::mem_cmd_t mem_cmd;  // Bridge to memory
  port_pkg::mem_rsp_t mem_rsp;

  apb_mc_bridge #(
    .NUM_THREAD (NUM_THREAD)
  ) bridge_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .mem_cmd (mem_cmd),
    .mem_rsp (mem_rsp)
  );

  mem_main #(
    .NUM_RT      (NUM_RT),
    .NUM_THREAD  (NUM_THREAD),
    .WORD_ADDR_W (WORD_ADDR_W)
  ) mem_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .rt_req  (rt_req),
    .rt_rsp  (rt_rsp),
    .mem_cmd (mem_cmd),
    .mem_rsp (mem_rsp)
  );

endmodule

//--- testbench/rt_mem_asserts.sv
`timescale 1ns/1ns

module rt_mem_asserts #(
  parameter int NUM_RT     = 4,
  parameter int NUM_THREAD = 8
) (
  input logic               clk,
  input logic               rst_n,
  input port_pkg::rt_req_t  rt_req [NUM_RT],
  input port_pkg::rt_rsp_t  rt_rsp [NUM_RT],
  input port_pkg::mem_rsp_t mem_rsp,
  input logic [NUM_RT-1:0]  acc_q,
  input logic [((NUM_THREAD > 1) ? $clog2(NUM_THREAD) : 1)-1:0] thr_q [NUM_RT]
);

  for (genvar p = 0; p < NUM_RT; p++) begin : g_port
    // A response needs a request held in the cycle before
    rdy_after_valid: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(rt_rsp[p].rdy) |-> $past(rt_req[p].valid))
      else $error("rdy rose on port %0d without a valid request", p);

    rdy_low_in_reset: assert property (@(posedge clk) !rst_n |-> !rt_rsp[p].rdy)
      else $error("rdy high during reset on port %0d", p);

    // One winner per thread and cycle
    for (genvar q = p + 1; q < NUM_RT; q++) begin : g_pair
      one_per_thread: assert property (@(posedge clk) disable iff (!rst_n)
        (acc_q[p] && acc_q[q]) |-> (thr_q[p] != thr_q[q]))
        else $error("ports %0d and %0d accepted on one thread", p, q);
    end
  end

  done_low_in_reset: assert property (@(posedge clk) !rst_n |-> !mem_rsp.done)
    else $error("mem_rsp.done high during reset");

endmodule

bind mem_main rt_mem_asserts #(
  .NUM_RT     (NUM_RT),
  .NUM_THREAD (NUM_THREAD)
) asserts_i (
  .clk     (clk),
  .rst_n   (rst_n),
  .rt_req  (rt_req),
  .rt_rsp  (rt_rsp),
  .mem_rsp (mem_rsp),
  .acc_q   (acc_q),
  .thr_q   (thr_q)
);

//--- testbench/tb_rt_mem.sv
`timescale 1ns/1ns

module tb_rt_mem;

  localparam int NUM_RT      = mem_pkg::DEF_NUM_RT;
  localparam int NUM_THREAD  = mem_pkg::DEF_NUM_THREAD;
  localparam int WORD_ADDR_W = mem_pkg::DEF_WORD_ADDR_W;
  localparam int NUM_WORDS   = 2**WORD_ADDR_W;
  localparam int WAIT_LIMIT  = 200;  // Cycles per wait

  logic               clk = 1'b0;
  logic               rst_n;
  port_pkg::apb_req_t apb_req;
  port_pkg::apb_rsp_t apb_rsp;
  port_pkg::rt_req_t  rt_req [NUM_RT];
  port_pkg::rt_rsp_t  rt_rsp [NUM_RT];

  logic [31:0]    shadow [NUM_THREAD][NUM_WORDS];  // Reference memory
  logic           cur_we [NUM_RT];
  int             cur_thr [NUM_RT];
  int             cur_word [NUM_RT];
  mem_pkg::line_t cur_wdata [NUM_RT];
  time            served_at [NUM_RT];  // When each port last saw rdy
  time            mc_done_at;
  mem_pkg::line_t staged;    // What DATA0..3 should hold
  mem_pkg::line_t mc_expect;
  integer         seed = 84;
  int             mismatches = 0;
  int             timeouts = 0;
  int             errors = 0;

  rt_mem_top #(
    .NUM_RT      (NUM_RT),
    .NUM_THREAD  (NUM_THREAD),
    .WORD_ADDR_W (WORD_ADDR_W)
  ) dut_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .rt_req  (rt_req),
    .rt_rsp  (rt_rsp)
  );

  always #4 clk = ~clk;

  function automatic mem_pkg::line_t expect_line(input int thr, input int word);
    mem_pkg::line_t l;
    for (int k = 0; k < mem_pkg::LANES; k++) begin
      l[k] = shadow[thr][(word + k) % NUM_WORDS];
    end
    return l;
  endfunction

  function automatic mem_pkg::line_t rand_line();
    mem_pkg::line_t l;
    for (int k = 0; k < mem_pkg::LANES; k++) begin
      l[k] = $random(seed);
    end
    return l;
  endfunction

  // ======================================================================
  // Compare process checks reads before writes land in the shadow
  // ======================================================================

  always @(negedge clk) begin
    for (int p = 0; p < NUM_RT; p++) begin
      if (rst_n && rt_rsp[p].rdy && !cur_we[p]) begin
        assert (rt_rsp[p].rdata == expect_line(cur_thr[p], cur_word[p])) else begin
          $display("Mismatch at %0t: port %0d thread %0d word %0d got %h expected %h",
                   $time, p, cur_thr[p], cur_word[p], rt_rsp[p].rdata,
                   expect_line(cur_thr[p], cur_word[p]));
          mismatches++;
        end
      end
    end
    for (int p = 0; p < NUM_RT; p++) begin
      if (rst_n && rt_rsp[p].rdy && cur_we[p]) begin
        for (int k = 0; k < mem_pkg::LANES; k++) begin
          shadow[cur_thr[p]][(cur_word[p] + k) % NUM_WORDS] = cur_wdata[p][k];
        end
      end
    end
  end

  // ======================================================================
  // RT and APB drivers
  // ======================================================================

  task automatic rt_access(input int p, input logic we, input int thr, input int word,
                           input mem_pkg::line_t data);
    port_pkg::rt_req_t r;
    int n;
    r = '0;
    r.valid = 1'b1;
    r.we = we;
    r.addr.thread = 6'(thr);
    r.addr.word = 12'(word);
    r.wdata = data;
    @(negedge clk);
    cur_we[p] = we;
    cur_thr[p] = thr;
    cur_word[p] = word;
    cur_wdata[p] = data;
    rt_req[p] = r;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!rt_rsp[p].rdy && n < WAIT_LIMIT);
    if (!rt_rsp[p].rdy) begin
      $display("Timeout at %0t: port %0d never got rdy", $time, p);
      timeouts++;
    end else begin
      served_at[p] = $time;
    end
    rt_req[p] = '0;
  endtask

  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    int n;
    @(negedge clk);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(negedge clk);
    apb_req.penable = 1'b1;
    n = 0;
    #2;
    while (!apb_rsp.pready && n < WAIT_LIMIT) begin
      @(negedge clk);
      #2;
      n++;
    end
    rdata = apb_rsp.prdata;
    err = apb_rsp.pslverr;
    if (!apb_rsp.pready) begin
      $display("Timeout at %0t: APB access to 0x%h never completed", $time, addr);
      timeouts++;
    end else if (wr && addr == port_pkg::REG_CMD && !err) begin
      // The line moved at the MC accept edge
      mc_done_at = $time;
      if (wdata[port_pkg::CMD_WE_BIT]) begin
        for (int k = 0; k < mem_pkg::LANES; k++) begin
          shadow[wdata[17:12]][(wdata[11:0] + k) % NUM_WORDS] = staged[k];
        end
      end else begin
        mc_expect = expect_line(wdata[17:12], wdata[11:0]);
        staged = mc_expect;
      end
    end
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic stage_line(input mem_pkg::line_t l);
    logic [31:0] rd;
    logic err;
    for (int k = 0; k < mem_pkg::LANES; k++) begin
      apb_xfer(1'b1, 8'(4 * k), l[k], rd, err);
    end
    staged = l;
  endtask

  task automatic mc_cmd(input logic we, input int thr, input int word, output logic err);
    logic [31:0] rd;
    apb_xfer(1'b1, port_pkg::REG_CMD, {we, 13'b0, 6'(thr), 12'(word)}, rd, err);
  endtask

  task automatic check_data_regs();
    logic [31:0] rd;
    logic err;
    for (int k = 0; k < mem_pkg::LANES; k++) begin
      apb_xfer(1'b0, 8'(4 * k), '0, rd, err);
      assert (rd == mc_expect[k]) else begin
        $display("Mismatch at %0t: DATA%0d got %h expected %h", $time, k, rd, mc_expect[k]);
        mismatches++;
      end
    end
  endtask

  // ======================================================================
  // Test sequence
  // ======================================================================

  initial begin
    logic err;
    logic [31:0] rd;
    mem_pkg::line_t l;
    int w;
    rst_n = 1'b0;
    apb_req = '0;
    staged = '0;
    mc_expect = '0;
    mc_done_at = 0;
    for (int p = 0; p < NUM_RT; p++) begin
      rt_req[p] = '0;
      cur_we[p] = 1'b1;
      cur_thr[p] = 0;
      cur_word[p] = 0;
      cur_wdata[p] = '0;
      served_at[p] = 0;
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    // Fill every thread so that no read sees undefined data
    for (int t = 0; t < NUM_THREAD; t++) begin
      for (int a = 0; a < NUM_WORDS; a += 4) begin
        rt_access(t % NUM_RT, 1'b1, t, a, rand_line());
      end
    end

    // Rotation at every start offset
    for (int off = 0; off < 4; off++) begin
      w = 16 + 8 * off + off;
      rt_access(0, 1'b1, 1, w, rand_line());
      rt_access(0, 1'b0, 1, w, '0);
      rt_access(0, 1'b0, 1, w - 1, '0);
    end
    rt_access(0, 1'b1, 1, NUM_WORDS - 2, rand_line());  // Wraps within the thread
    rt_access(0, 1'b0, 1, NUM_WORDS - 2, '0);

    // Four ports on four threads
    fork
      rt_access(0, 1'b1, 0, 40, rand_line());
      rt_access(1, 1'b0, 1, 17, '0);
      rt_access(2, 1'b1, 2, 83, rand_line());
      rt_access(3, 1'b0, 3, 120, '0);
    join
    fork
      rt_access(0, 1'b0, 0, 40, '0);
      rt_access(1, 1'b0, 2, 83, '0);
      rt_access(2, 1'b0, 3, 121, '0);
      rt_access(3, 1'b0, 1, 18, '0);
    join

    // Contention on one thread
    for (int r = 0; r < 4; r++) begin
      fork
        rt_access(0, 1'b1, 5, 60, rand_line());
        rt_access(1, 1'b0, 5, 61, '0);
        rt_access(2, 1'b1, 5, 62, rand_line());
        rt_access(3, 1'b0, 5, 59, '0);
      join
      for (int p = 1; p < NUM_RT; p++) begin
        assert (served_at[p] > served_at[p - 1]) else begin
          $display("Port %0d was served before port %0d on a shared thread", p, p - 1);
          errors++;
        end
      end
    end

    // MC write read back by RT and RT write read back by MC
    l = rand_line();
    stage_line(l);
    mc_cmd(1'b1, 4, 101, err);
    rt_access(1, 1'b0, 4, 101, '0);
    rt_access(2, 1'b1, 7, 33, rand_line());
    mc_cmd(1'b0, 7, 33, err);
    check_data_regs();

    // MC and RT on one thread at once
    stage_line(rand_line());
    fork
      mc_cmd(1'b1, 6, 30, err);
      begin
        repeat (2) @(negedge clk);  // Request lands while mem_cmd is valid
        rt_access(1, 1'b0, 6, 31, '0);
      end
    join
    assert (served_at[1] > mc_done_at) else begin
      $display("Port 1 was served ahead of the MC write on thread 6");
      errors++;
    end
    fork
      mc_cmd(1'b0, 6, 30, err);
      begin
        repeat (2) @(negedge clk);
        rt_access(2, 1'b1, 6, 32, rand_line());
      end
    join
    assert (served_at[2] > mc_done_at) else begin
      $display("Port 2 was served ahead of the MC read on thread 6");
      errors++;
    end
    check_data_regs();

    // Out-of-range thread
    apb_xfer(1'b0, port_pkg::REG_STATUS, '0, rd, err);
    assert (!rd[port_pkg::STAT_ERR_BIT]) else begin
      $display("STATUS error bit was already set before the bad command");
      errors++;
    end
    mc_cmd(1'b1, NUM_THREAD + 1, 101, err);
    assert (err) else begin
      $display("Command with an out-of-range thread was not refused");
      errors++;
    end
    apb_xfer(1'b0, port_pkg::REG_STATUS, '0, rd, err);
    assert (rd[port_pkg::STAT_ERR_BIT]) else begin
      $display("STATUS error bit not set after the refused command");
      errors++;
    end
    rt_access(0, 1'b0, 4, 101, '0);
    rt_access(0, 1'b0, NUM_THREAD + 1 - NUM_THREAD, 101, '0);

    repeat (4) @(negedge clk);
    $display("Checks done: %0d mismatches, %0d timeouts, %0d other errors",
             mismatches, timeouts, errors);
    if (mismatches + timeouts + errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
hw/mem_pkg.sv
hw/port_pkg.sv
hw/bank_ram.sv
hw/thread_group.sv
hw/mem_main.sv
hw/apb_mc_bridge.sv
hw/rt_mem_top.sv
testbench/rt_mem_asserts.sv
testbench/tb_rt_mem.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator, result taken from sim.log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_rt_mem \
  -o tb_rt_mem > sim.log 2>&1 &&
  ./obj_dir/tb_rt_mem >> sim.log 2>&1 ||
  echo "Build or simulation stopped with an error" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0
